/* src/gbt_cfg.svh */
// width settings for the console io block
// softcore word address, data widths, joypad button count
//
// all widths are fixed by the sdram and softcore word sizes

`ifndef GBT_CFG_SVH
`define GBT_CFG_SVH

//////////////////////////////////////////////////
// softcore side
//////////////////////////////////////////////////
`define GBT_CPU_ADDR_W  19      // word address, byte bits dropped
`define GBT_WORD_W      32      // softcore data word

//////////////////////////////////////////////////
// sdram side
//////////////////////////////////////////////////
`define GBT_HALF_W      16      // one sdram half word

// nes pad: A B Select Start Up Down Left Right
`define GBT_PAD_BITS    8

`endif

/* src/gbt_pkg.sv */
// shared types for the console io block
// vector typedefs for addresses, data, strobes, pad buttons
// bridge fsm state enum

`include "gbt_cfg.svh"

package gbt_pkg;

    // address and data
    typedef logic [`GBT_CPU_ADDR_W-1:0] cpu_addr_t;    // softcore word addr
    typedef logic [`GBT_CPU_ADDR_W:0]   mem_addr_t;    // word addr + half select
    typedef logic [`GBT_WORD_W-1:0]     cpu_word_t;
    typedef logic [`GBT_HALF_W-1:0]     mem_half_t;

    // byte enables
    typedef logic [`GBT_WORD_W/8-1:0]   byte_strobe_t; // one per byte of a word
    typedef logic [`GBT_HALF_W/8-1:0]   half_strobe_t; // sdram ds pair

    // bit 0 = A ... bit 7 = Right
    typedef logic [`GBT_PAD_BITS-1:0]   pad_buttons_t;

    typedef enum logic [2:0] {
        BR_IDLE,        // waiting for softcore request
        BR_WAIT_LO,     // lower half open
        BR_CAPTURE_LO,  // latch lower read data
        BR_WAIT_HI,     // upper half open
        BR_CAPTURE_HI   // return full word
    } bridge_state_t;

endpackage

/* src/half_word_bridge.sv */
// softcore to sdram bridge
// one 32-bit softcore access becomes one or two 16-bit sdram accesses
// sdram side uses a toggle handshake, request open while req != ack

`timescale 1ns/1ps

`include "gbt_cfg.svh"

module half_word_bridge
    import gbt_pkg::*;
(
    input  logic          clk,
    input  logic          sys_resetn,

    // softcore side
    input  logic          i_cpu_valid,
    input  cpu_addr_t     i_cpu_addr,
    input  cpu_word_t     i_cpu_wdata,
    input  byte_strobe_t  i_cpu_wstrb,   // all zero = read
    output cpu_word_t     o_cpu_rdata,
    output logic          o_cpu_ready,   // single cycle pulse

    // sdram side
    output logic          o_mem_req,     // toggles per request
    output mem_addr_t     o_mem_addr,
    output mem_half_t     o_mem_din,
    output half_strobe_t  o_mem_ds,
    output logic          o_mem_we,
    input  logic          i_mem_ack,     // toggles when done
    input  mem_half_t     i_mem_dout
);

bridge_state_t  state;
logic           valid_q;        // last i_cpu_valid, for edge detect
logic           pending;        // edge seen while busy
logic           half_sel;       // 0 lower half, 1 upper half
mem_half_t      lo_hold;        // lower read half

logic           new_req;
logic           is_write;
logic           mem_done;
half_strobe_t   lo_strb;
half_strobe_t   hi_strb;

assign new_req  = i_cpu_valid & ~valid_q;
assign is_write = |i_cpu_wstrb;
assign mem_done = (o_mem_req == i_mem_ack);  // no request open
assign lo_strb  = i_cpu_wstrb[1:0];
assign hi_strb  = i_cpu_wstrb[3:2];

// host holds addr/data until ready, so steer straight from the inputs
assign o_mem_addr = {i_cpu_addr, half_sel};
assign o_mem_din  = half_sel ? i_cpu_wdata[`GBT_WORD_W-1:`GBT_HALF_W]
                             : i_cpu_wdata[`GBT_HALF_W-1:0];

//////////////////////////////////////////////////
// request fsm
//////////////////////////////////////////////////
always_ff @(posedge clk) begin
    if (!sys_resetn) begin
        state       <= BR_IDLE;
        valid_q     <= 1'b0;
        pending     <= 1'b0;
        half_sel    <= 1'b0;
        o_cpu_ready <= 1'b0;
        o_mem_req   <= 1'b0;
        o_mem_ds    <= '0;
        o_mem_we    <= 1'b0;
    end else begin
        valid_q     <= i_cpu_valid;
        o_cpu_ready <= 1'b0;            // pulse default
        if (new_req)
            pending <= 1'b1;            // remembered if busy

        case (state)
            BR_IDLE: begin
                if (new_req || pending) begin
                    pending   <= 1'b0;
                    o_mem_req <= ~o_mem_req;
                    o_mem_we  <= is_write;  // latched for whole access
                    if (is_write && lo_strb == '0) begin
                        // lower half untouched, go straight up
                        half_sel <= 1'b1;
                        o_mem_ds <= hi_strb;
                        state    <= BR_WAIT_HI;
                    end else begin
                        half_sel <= 1'b0;
                        o_mem_ds <= is_write ? lo_strb : 2'b11;
                        state    <= BR_WAIT_LO;
                    end
                end
            end

            BR_WAIT_LO: begin
                if (mem_done) begin
                    if (!o_mem_we) begin
                        state <= BR_CAPTURE_LO;     // read, data one cycle on
                    end else if (hi_strb == '0) begin
                        o_cpu_ready <= 1'b1;        // lower-only write done
                        state       <= BR_IDLE;
                    end else begin
                        o_mem_req <= ~o_mem_req;    // upper write
                        half_sel  <= 1'b1;
                        o_mem_ds  <= hi_strb;
                        state     <= BR_WAIT_HI;
                    end
                end
            end

            BR_CAPTURE_LO: begin
                // lower data latched this cycle, issue upper read
                o_mem_req <= ~o_mem_req;
                half_sel  <= 1'b1;
                o_mem_ds  <= 2'b11;
                state     <= BR_WAIT_HI;
            end

            BR_WAIT_HI: begin
                if (mem_done) begin
                    if (o_mem_we) begin
                        o_cpu_ready <= 1'b1;
                        state       <= BR_IDLE;
                    end else begin
                        state <= BR_CAPTURE_HI;
                    end
                end
            end

            BR_CAPTURE_HI: begin
                o_cpu_ready <= 1'b1;            // rdata valid with this
                state       <= BR_IDLE;
            end

            default: state <= BR_IDLE;
        endcase
    end
end

//////////////////////////////////////////////////
// read data path
//////////////////////////////////////////////////
// dout is held by the sdram side until the next request
always_ff @(posedge clk) begin
    if (state == BR_CAPTURE_LO)
        lo_hold <= i_mem_dout;
    if (state == BR_CAPTURE_HI)
        o_cpu_rdata <= {i_mem_dout, lo_hold};   // upper : lower
end

endmodule

/* src/joypad_shifter.sv */
// one serial nes joypad port
// button latch while strobe high, right shift on falling pad clock

`timescale 1ns/1ps

`include "gbt_cfg.svh"

module joypad_shifter
    import gbt_pkg::*;
(
    input  logic          clk,
    input  logic          sys_resetn,
    input  logic          i_strobe,      // latch buttons while high
    input  logic          i_pad_clk,     // shift clock from the console
    input  pad_buttons_t  i_buttons,     // A in bit 0
    output logic          o_data         // serial button bit
);

pad_buttons_t  shift_q;
logic          pad_clk_q;               // registered pad clock
logic          pad_clk_fall;

// edge against the registered copy, so shift lands one cycle after the fall
assign pad_clk_fall = pad_clk_q & ~i_pad_clk;

//////////////////////////////////////////////////
// latch and shift
//////////////////////////////////////////////////
always_ff @(posedge clk) begin
    if (!sys_resetn) begin
        shift_q   <= '1;                // idle line high
        pad_clk_q <= 1'b0;
    end else begin
        pad_clk_q <= i_pad_clk;
        if (i_strobe) begin
            shift_q <= i_buttons;       // reload every cycle
        end else if (pad_clk_fall) begin
            // ones fill from the top, extra clocks read high
            shift_q <= {1'b1, shift_q[`GBT_PAD_BITS-1:1]};
        end
    end
end

// current bit 0 straight from the shift register
assign o_data = shift_q[0];

endmodule

/* src/gbt_io_top.sv */
// console io top level
// softcore to sdram half-word bridge
// two serial joypad ports sharing one strobe

`timescale 1ns/1ps

module gbt_io_top
    import gbt_pkg::*;
(
    input  logic          clk,
    input  logic          sys_resetn,

    // softcore memory port
    input  logic          i_cpu_valid,
    input  cpu_addr_t     i_cpu_addr,
    input  cpu_word_t     i_cpu_wdata,
    input  byte_strobe_t  i_cpu_wstrb,
    output cpu_word_t     o_cpu_rdata,
    output logic          o_cpu_ready,

    // sdram half-word port
    output logic          o_mem_req,
    output mem_addr_t     o_mem_addr,
    output mem_half_t     o_mem_din,
    output half_strobe_t  o_mem_ds,
    output logic          o_mem_we,
    input  logic          i_mem_ack,
    input  mem_half_t     i_mem_dout,

    // joypads, bit 0 = pad 1
    input  logic          i_joy_strobe,
    input  logic [1:0]    i_joy_clk,
    input  pad_buttons_t  i_pad1_btns,
    input  pad_buttons_t  i_pad2_btns,
    output logic [1:0]    o_joy_data
);

//////////////////////////////////////////////////
// memory bridge
//////////////////////////////////////////////////
half_word_bridge u_bridge (
    .clk         (clk),
    .sys_resetn  (sys_resetn),
    .i_cpu_valid (i_cpu_valid),
    .i_cpu_addr  (i_cpu_addr),
    .i_cpu_wdata (i_cpu_wdata),
    .i_cpu_wstrb (i_cpu_wstrb),
    .o_cpu_rdata (o_cpu_rdata),
    .o_cpu_ready (o_cpu_ready),
    .o_mem_req   (o_mem_req),
    .o_mem_addr  (o_mem_addr),
    .o_mem_din   (o_mem_din),
    .o_mem_ds    (o_mem_ds),
    .o_mem_we    (o_mem_we),
    .i_mem_ack   (i_mem_ack),
    .i_mem_dout  (i_mem_dout)
);

//////////////////////////////////////////////////
// joypad ports
//////////////////////////////////////////////////
joypad_shifter u_pad1 (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .i_strobe   (i_joy_strobe),    // shared strobe
    .i_pad_clk  (i_joy_clk[0]),
    .i_buttons  (i_pad1_btns),
    .o_data     (o_joy_data[0])
);

joypad_shifter u_pad2 (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .i_strobe   (i_joy_strobe),
    .i_pad_clk  (i_joy_clk[1]),    // own clock per port
    .i_buttons  (i_pad2_btns),
    .o_data     (o_joy_data[1])
);

endmodule

/* verification/gbt_io_assert.sv */
// concurrent checks on the bridge sdram handshake
// bound into every half_word_bridge instance

`timescale 1ns/1ps

module gbt_io_assert
    import gbt_pkg::*;
(
    input logic          clk,
    input logic          sys_resetn,
    input logic          o_cpu_ready,
    input logic          o_mem_req,
    input logic          i_mem_ack,
    input mem_addr_t     o_mem_addr,
    input mem_half_t     o_mem_din,
    input half_strobe_t  o_mem_ds
);

// ready is a single cycle pulse
a_ready_pulse: assert property (@(posedge clk) disable iff (!sys_resetn)
    o_cpu_ready |=> !o_cpu_ready)
    else $error("o_cpu_ready high two cycles running");

// new toggle only once the last request closed
a_req_closed: assert property (@(posedge clk) disable iff (!sys_resetn)
    (o_mem_req != $past(o_mem_req)) |-> ($past(o_mem_req) == $past(i_mem_ack)))
    else $error("o_mem_req toggled with a request still open");

a_ds_nonzero: assert property (@(posedge clk) disable iff (!sys_resetn)
    (o_mem_req != $past(o_mem_req)) |-> (o_mem_ds != '0))
    else $error("o_mem_req toggled with o_mem_ds zero");

// addr and data frozen while open
a_stable: assert property (@(posedge clk) disable iff (!sys_resetn)
    ((o_mem_req == $past(o_mem_req)) && $past(o_mem_req != i_mem_ack))
    |-> ($stable(o_mem_addr) && $stable(o_mem_din)))
    else $error("o_mem_addr or o_mem_din moved during an open request");

endmodule

bind half_word_bridge gbt_io_assert u_bridge_assert (
    .clk         (clk),
    .sys_resetn  (sys_resetn),
    .o_cpu_ready (o_cpu_ready),
    .o_mem_req   (o_mem_req),
    .i_mem_ack   (i_mem_ack),
    .o_mem_addr  (o_mem_addr),
    .o_mem_din   (o_mem_din),
    .o_mem_ds    (o_mem_ds)
);

/* verification/tb_gbt_io.sv */
// testbench for the console io block
// sdram responder model with random ack delay, case file reader
// bridge and joypad checks, per-case lines and summary

`timescale 1ns/1ps

`include "gbt_cfg.svh"

module tb_gbt_io
    import gbt_pkg::*;
();

logic          clk;
logic          sys_resetn   = 1'b0;
logic          i_cpu_valid  = 1'b0;
cpu_addr_t     i_cpu_addr   = '0;
cpu_word_t     i_cpu_wdata  = '0;
byte_strobe_t  i_cpu_wstrb  = '0;
cpu_word_t     o_cpu_rdata;
logic          o_cpu_ready;
logic          o_mem_req;
mem_addr_t     o_mem_addr;
mem_half_t     o_mem_din;
half_strobe_t  o_mem_ds;
logic          o_mem_we;
logic          i_mem_ack    = 1'b0;
mem_half_t     i_mem_dout   = '0;
logic          i_joy_strobe = 1'b0;
logic [1:0]    i_joy_clk    = 2'b00;
pad_buttons_t  i_pad1_btns  = '0;
pad_buttons_t  i_pad2_btns  = '0;
logic [1:0]    o_joy_data;

mem_half_t     shadow [mem_addr_t];     // sdram contents, sparse
mem_half_t     wr_half;
integer        seed      = 32'hbd5c9f00;
logic          busy      = 1'b0;        // request accepted, ack pending
int            delay     = 0;
logic          req_seen  = 1'b0;        // o_mem_req at last falling edge
int            toggles   = 0;
int            readies   = 0;
int            errors    = 0;
int            cases_run = 0;
int            cases_bad = 0;
logic          aborted   = 1'b0;

gbt_io_top u_dut (.*);

initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
end

// unwritten locations read back a pattern of the full address
function automatic mem_half_t shadow_rd(mem_addr_t a);
    if (shadow.exists(a))
        return shadow[a];
    return a[15:0] ^ {a[19:16], a[19:16], a[19:16], a[19:16]} ^ 16'h5a5a;
endfunction

//////////////////////////////////////////////////
// sdram responder and event counters
//////////////////////////////////////////////////
always @(negedge clk) begin
    if (!sys_resetn) begin
        busy     = 1'b0;
        req_seen = 1'b0;
    end else begin
        if (o_mem_req != req_seen)
            toggles = toggles + 1;
        if (o_cpu_ready)
            readies = readies + 1;
        req_seen = o_mem_req;
        if (o_mem_req != i_mem_ack) begin
            if (!busy) begin
                busy  = 1'b1;
                delay = $unsigned($random(seed)) % 4;   // 1 to 4 edges
            end
            if (delay == 0) begin
                if (o_mem_we) begin
                    wr_half = shadow_rd(o_mem_addr);
                    if (o_mem_ds[0])
                        wr_half[7:0] = o_mem_din[7:0];
                    if (o_mem_ds[1])
                        wr_half[15:8] = o_mem_din[15:8];
                    shadow[o_mem_addr] = wr_half;
                end else begin
                    i_mem_dout = shadow_rd(o_mem_addr);  // held till next req
                end
                i_mem_ack = ~i_mem_ack;
                busy      = 1'b0;
            end else begin
                delay = delay - 1;
            end
        end
    end
end

//////////////////////////////////////////////////
// case tasks
//////////////////////////////////////////////////
task automatic mem_access(input logic is_rd, input cpu_addr_t addr, input cpu_word_t wdata,
                          input byte_strobe_t wstrb, input logic [31:0] exp,
                          output logic bad);
    int         t0;
    int         r0;
    int         n;
    int         want_req;
    cpu_word_t  got;
    cpu_word_t  model;
    bad         = 1'b0;
    t0          = toggles;
    r0          = readies;
    want_req    = is_rd ? 2 : int'(exp);   // a read always takes both halves
    i_cpu_addr  = addr;
    i_cpu_wdata = wdata;
    i_cpu_wstrb = wstrb;
    i_cpu_valid = 1'b1;
    n = 0;
    do begin
        @(negedge clk);
        n++;
    end while (!o_cpu_ready && n < 200);
    got   = o_cpu_rdata;                 // valid in the ready cycle
    model = {shadow_rd({addr, 1'b1}), shadow_rd({addr, 1'b0})};
    i_cpu_valid = 1'b0;
    if (!o_cpu_ready) begin
        $display("case %0d: timeout, o_cpu_ready not seen within 200 cycles", cases_run);
        bad     = 1'b1;
        aborted = 1'b1;
    end else begin
        repeat (2) @(negedge clk);       // room for a stray second pulse
        assert (readies - r0 == 1) else begin
            $display("o_cpu_ready pulsed %0d times for one request", readies - r0);
            bad = 1'b1;
        end
        assert (toggles - t0 == want_req) else begin
            $display("Mismatch o_mem_req toggles: got %h expected %h",
                     toggles - t0, want_req);
            bad = 1'b1;
        end
        if (is_rd) begin
            assert (got == exp) else begin
                $display("Mismatch o_cpu_rdata: got %h expected %h", got, exp);
                bad = 1'b1;
            end
            assert (got == model) else begin
                $display("Mismatch o_cpu_rdata vs sdram: got %h expected %h", got, model);
                bad = 1'b1;
            end
        end
    end
endtask

// strobe both pads, clock one of them 10 times
task automatic pad_read(input logic idx, input pad_buttons_t other, input pad_buttons_t btns,
                        input logic [10:0] exp, output logic bad);
    logic [10:0] got;
    bad = 1'b0;
    got = '0;
    i_pad1_btns  = idx ? other : btns;
    i_pad2_btns  = idx ? btns : other;
    i_joy_strobe = 1'b1;
    @(negedge clk);
    i_joy_strobe = 1'b0;
    @(negedge clk);
    for (int k = 0; k < 11; k++) begin
        got = {o_joy_data[idx], got[10:1]};     // first bit ends in bit 0
        assert (o_joy_data[~idx] == other[0]) else begin
            $display("Mismatch o_joy_data[%0d]: got %h expected %h",
                     ~idx, o_joy_data[~idx], other[0]);
            bad = 1'b1;
        end
        if (k < 10) begin
            i_joy_clk[idx] = 1'b1;
            @(negedge clk);
            i_joy_clk[idx] = 1'b0;
            @(negedge clk);                     // shift lands here
        end
    end
    assert (got == exp) else begin
        $display("Mismatch o_joy_data[%0d] serial: got %h expected %h", idx, got, exp);
        bad = 1'b1;
    end
endtask

//////////////////////////////////////////////////
// main sequence
//////////////////////////////////////////////////
initial begin
    int           fd;
    int           code;
    int           c;
    logic [7:0]   kind;
    logic [31:0]  f_addr;
    logic [31:0]  f_data;
    logic [31:0]  f_strb;
    logic [31:0]  f_exp;
    logic         bad;
    repeat (8) @(posedge clk);
    @(negedge clk);
    sys_resetn = 1'b1;
    @(negedge clk);
    assert (o_joy_data == 2'b11) else begin
        $display("Mismatch o_joy_data after reset: got %h expected 3", o_joy_data);
        errors++;
    end
    fd = $fopen("verification/gbt_io_cases.txt", "r");
    if (fd == 0) begin
        $display("could not open the case file");
        errors++;
    end else begin
        while (!aborted && $fscanf(fd, " %c", kind) == 1) begin
            if (kind == "#") begin
                c = 0;
                while (c != 10 && c != -1)      // skip to newline
                    c = $fgetc(fd);
            end else begin
                bad  = 1'b0;
                code = $fscanf(fd, " %h %h %h %h", f_addr, f_data, f_strb, f_exp);
                cases_run++;
                if (code != 4) begin
                    $display("case %0d: line has %0d fields after the kind", cases_run, code);
                    bad = 1'b1;
                end else if (kind == "W" || kind == "R") begin
                    mem_access(kind == "R", f_addr[`GBT_CPU_ADDR_W-1:0], f_data,
                               f_strb[3:0], f_exp, bad);
                end else if (kind == "P") begin
                    pad_read(f_addr[0], f_data[7:0], f_strb[7:0], f_exp[10:0], bad);
                end else begin
                    $display("case %0d: unknown kind %c", cases_run, kind);
                    bad = 1'b1;
                end
                if (bad)
                    cases_bad++;
                $display("case %0d %c %h: %s", cases_run, kind, f_addr, bad ? "fail" : "pass");
            end
        end
        $fclose(fd);
    end
    $display("%0d cases, %0d passed, %0d failed, %0d other errors",
             cases_run, cases_run - cases_bad, cases_bad, errors);
    if (errors == 0 && cases_bad == 0 && cases_run > 0 && !aborted)
        $display("TEST OK");
    else
        $display("TEST FAILED");
    $finish;
end

endmodule

/* src.f */
+incdir+src
src/gbt_pkg.sv
src/half_word_bridge.sv
src/joypad_shifter.sv
src/gbt_io_top.sv
verification/gbt_io_assert.sv
verification/tb_gbt_io.sv

/* Makefile */
# verilator build and run for the console io testbench

VERILATOR ?= verilator
TOP       ?= tb_gbt_io
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= TEST OK

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the simulation prints the pass line
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verification/gbt_io_cases.txt */
# kind addr data strb expect, all hex
# W expect = sdram requests, R expect = word, P addr = pad, data = other pad, strb = buttons
W 00010 deadbeef f 2
R 00010 00000000 0 deadbeef
W 00020 11223344 f 2
W 00020 aaaa5555 3 1
R 00020 00000000 0 11225555
W 00020 bbbb6666 c 1
R 00020 00000000 0 bbbb5555
W 00030 01020304 f 2
W 00030 ffffff99 1 1
W 00030 ff77ffff 4 1
W 00030 88ffffff 8 1
W 00030 ffff55ff 2 1
R 00030 00000000 0 88775599
W 00031 00000000 f 2
W 00031 12345678 6 2
R 00031 00000000 0 00345600
W 7ffff cafef00d f 2
R 7ffff 00000000 0 cafef00d
R 00010 00000000 0 deadbeef
P 0 3c a5 7a5
P 1 ff 5a 75a
P 0 00 ff 7ff
P 1 81 00 700
